/* sram_sys.f */
+incdir+include
design/sram_pkg.sv
design/sram_bus_if.sv
design/sram_bank_ctrl.sv
design/sram_bank_router.sv
design/sram_sys_top.sv
verif/sram_chip_model.sv
verif/sram_sys_sva.sv
verif/sram_sys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the SRAM subsystem testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sram_sys_sim
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module sram_sys_tb -f sram_sys.f \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG_FILE"; then
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG_FILE"; then
	echo "Simulation log holds no result line"
	exit 1
fi
exit 0

/* verif/sram_sys_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_sys_tb
	import sram_pkg::*;
();
	localparam int CLK_PERIOD = 40;
	localparam int RAND_TXN = 200;
	localparam int TOTAL_TXN = 22 + RAND_TXN;
	localparam logic [`SRAM_DATA_W-1:0] BASE_KEY = 32'h5a3c_0000;
	localparam logic [`SRAM_DATA_W-1:0] EXT_KEY = 32'hc3a5_0000;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	sram_op_e req_op;
	logic [`SYS_ADDR_W-1:0] req_addr;
	logic [`SRAM_DATA_W-1:0] req_wdata;
	logic rsp_valid;
	logic rsp_ready;
	logic [`SRAM_DATA_W-1:0] rsp_rdata;
	logic [`SRAM_ADDR_W-1:0] base_addr;
	wire  [`SRAM_DATA_W-1:0] base_data;
	logic base_ce_n;
	logic base_oe_n;
	logic base_we_n;
	logic [`SRAM_ADDR_W-1:0] ext_addr;
	wire  [`SRAM_DATA_W-1:0] ext_data;
	logic ext_ce_n;
	logic ext_oe_n;
	logic ext_we_n;

	logic [`SRAM_DATA_W-1:0] ref_mem [logic [`SYS_ADDR_W-1:0]];
	logic [`SRAM_DATA_W-1:0] exp_q [$];
	int acc_q [$];
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	logic bp_en = 1'b0;
	logic lat_check = 1'b0;

	sram_sys_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_rdata (rsp_rdata),
		.base_addr (base_addr),
		.base_data (base_data),
		.base_ce_n (base_ce_n),
		.base_oe_n (base_oe_n),
		.base_we_n (base_we_n),
		.ext_addr  (ext_addr),
		.ext_data  (ext_data),
		.ext_ce_n  (ext_ce_n),
		.ext_oe_n  (ext_oe_n),
		.ext_we_n  (ext_we_n)
	);

	sram_chip_model #(.FILL_KEY(BASE_KEY)) u_base_mem (
		.addr (base_addr),
		.data (base_data),
		.ce_n (base_ce_n),
		.oe_n (base_oe_n),
		.we_n (base_we_n)
	);

	sram_chip_model #(.FILL_KEY(EXT_KEY)) u_ext_mem (
		.addr (ext_addr),
		.data (ext_data),
		.ce_n (ext_ce_n),
		.oe_n (ext_oe_n),
		.we_n (ext_we_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [`SRAM_DATA_W-1:0] fill_word(input logic [`SYS_ADDR_W-1:0] addr);
		logic [`SRAM_ADDR_W-1:0] a;
		a = addr[`SRAM_ADDR_W-1:0];
		return {a[11:0], a} ^ (addr[`SYS_ADDR_W-1] ? EXT_KEY : BASE_KEY);
	endfunction

	function automatic logic [`SRAM_DATA_W-1:0] ref_word(input logic [`SYS_ADDR_W-1:0] addr);
		if (ref_mem.exists(addr)) begin
			return ref_mem[addr];
		end
		return fill_word(addr); // Never written.
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
		end
	endtask

	task automatic send_req(input sram_op_e op, input logic [`SYS_ADDR_W-1:0] addr,
		input logic [`SRAM_DATA_W-1:0] wdata);
		req_valid <= 1'b1;
		req_op <= op;
		req_addr <= addr;
		req_wdata <= wdata;
		@(posedge clk);
		while (!req_ready) begin
			@(posedge clk);
		end
		req_valid <= 1'b0;
	endtask

	task automatic drain_responses();
		do begin
			@(negedge clk);
		end while (exp_q.size() != 0);
		@(posedge clk);
	endtask

	// Accepted requests update the reference.
	initial begin
		forever begin
			@(posedge clk);
			if (rst && req_valid && req_ready) begin
				if (req_op == OP_WRITE) begin
					ref_mem[req_addr] = req_wdata;
				end else begin
					exp_q.push_back(ref_word(req_addr));
					acc_q.push_back(cycle);
				end
			end
		end
	end

	initial begin
		logic [`SRAM_DATA_W-1:0] exp_word;
		int acc;
		forever begin
			@(posedge clk);
			if (rst && rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Response at %0t arrived with no read outstanding", $time);
				end else begin
					exp_word = exp_q.pop_front();
					acc = acc_q.pop_front();
					check_value("read data", rsp_rdata, exp_word);
					if (lat_check) begin
						check_value("read latency", 32'(cycle - acc), 32'd4);
					end
				end
			end
		end
	end

	initial begin
		rsp_ready = 1'b0;
		forever begin
			@(posedge clk);
			rsp_ready <= bp_en ? (($urandom % 100) < 32'd60) : 1'b1;
		end
	end

	initial begin
		repeat (TOTAL_TXN * 20) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_TXN * 20);
		$display("RESULT: FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [`SRAM_ADDR_W-1:0] a;
		logic [31:0] rnd;
		void'($urandom(45852));
		rst = 1'b0;
		req_valid = 1'b0;
		req_op = OP_WRITE;
		req_addr = '0;
		req_wdata = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);

		check_value("req_ready after reset", {31'd0, req_ready}, 32'd1);
		check_value("rsp_valid after reset", {31'd0, rsp_valid}, 32'd0);
		check_value("strobes after reset", {26'd0, base_ce_n, base_oe_n, base_we_n,
			ext_ce_n, ext_oe_n, ext_we_n}, 32'h3f);

		// Write then timed read back on the base bank.
		send_req(OP_WRITE, {1'b0, 20'h00123}, 32'hdead_beef);
		lat_check = 1'b1;
		send_req(OP_READ, {1'b0, 20'h00123}, '0);
		drain_responses();
		lat_check = 1'b0;

		// Same low address in both banks.
		a = 20'h0abcd;
		send_req(OP_WRITE, {1'b0, a}, 32'h1111_2222);
		send_req(OP_WRITE, {1'b1, a}, 32'h3333_4444);
		send_req(OP_READ, {1'b0, a}, '0);
		send_req(OP_READ, {1'b1, a}, '0);
		drain_responses();
		check_value("base chip word", u_base_mem.peek(a), ref_word({1'b0, a}));
		check_value("ext chip word", u_ext_mem.peek(a), ref_word({1'b1, a}));

		// Reads from alternating banks keep issue order.
		for (int i = 0; i < 8; i++) begin
			a = 20'h00400 + 20'(i);
			send_req(OP_WRITE, {1'(i % 2), a}, 32'h4000_0000 + 32'(i));
		end
		for (int i = 0; i < 8; i++) begin
			a = 20'h00400 + 20'(i);
			send_req(OP_READ, {1'(i % 2), a}, '0);
		end
		drain_responses();

		// Random traffic under back-pressure.
		bp_en <= 1'b1;
		for (int i = 0; i < RAND_TXN; i++) begin
			rnd = $urandom;
			a = {15'd0, rnd[4:0]}; // Small pool so reads hit writes.
			send_req(rnd[8] ? OP_WRITE : OP_READ, {rnd[31], a}, $urandom);
			if (rnd[12:11] == 2'd0) begin
				@(posedge clk);
			end
		end
		drain_responses();
		bp_en <= 1'b0;

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/sram_sys_sva.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_sys_sva (
	input logic clk,
	input logic rst,
	input logic ce_n,
	input logic oe_n,
	input logic we_n,
	input logic req_valid,
	input logic req_ready,
	input logic op,
	input logic [`SRAM_ADDR_W-1:0] addr,
	input logic [`SRAM_DATA_W-1:0] wdata
);
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SRAM pins
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_write_strobe: assert property (@(posedge clk) disable iff (!rst)
		!we_n |-> (!ce_n && oe_n))
		else $error("Write pulse without chip select or with output enable low.");

	a_no_bus_fight: assert property (@(posedge clk) disable iff (!rst)
		!(!oe_n && !we_n))
		else $error("Output enable and write enable low together.");

	a_reset_strobes: assert property (@(posedge clk)
		!rst |=> (ce_n && oe_n && we_n))
		else $error("Strobes not idle after reset.");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_req_stable: assert property (@(posedge clk) disable iff (!rst)
		(req_valid && !req_ready) |=>
		(req_valid && $stable(op) && $stable(addr) && $stable(wdata)))
		else $error("Request changed while waiting for ready.");

endmodule

bind sram_bank_ctrl sram_sys_sva u_sva (
	.clk       (clk),
	.rst       (rst),
	.ce_n      (ce_n),
	.oe_n      (oe_n),
	.we_n      (we_n),
	.req_valid (bus.req_valid),
	.req_ready (bus.req_ready),
	.op        (bus.op),
	.addr      (bus.addr),
	.wdata     (bus.wdata)
);

`default_nettype wire

/* verif/sram_chip_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_chip_model #(
	parameter logic [`SRAM_DATA_W-1:0] FILL_KEY = '0
) (
	input  wire [`SRAM_ADDR_W-1:0] addr,
	inout  wire [`SRAM_DATA_W-1:0] data,
	input  wire ce_n,
	input  wire oe_n,
	input  wire we_n
);
	logic [`SRAM_DATA_W-1:0] mem [logic [`SRAM_ADDR_W-1:0]];
	logic [`SRAM_DATA_W-1:0] rd_word;

	// Unwritten words read back a pattern built from the full address.
	function automatic logic [`SRAM_DATA_W-1:0] peek(input logic [`SRAM_ADDR_W-1:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return {a[11:0], a} ^ FILL_KEY;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(addr or ce_n or oe_n or we_n) begin
		rd_word = peek(addr);
	end

	assign data = (!ce_n && !oe_n && we_n) ? rd_word : {`SRAM_DATA_W{1'bz}};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(addr or data or ce_n or we_n) begin
		if (!ce_n && !we_n) begin
			mem[addr] = data; // Transparent while the pulse is low.
		end
	end

endmodule

`default_nettype wire

/* design/sram_sys_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_sys_top
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rst,

	input  logic req_valid,
	output logic req_ready,
	input  sram_op_e req_op,
	input  logic [`SYS_ADDR_W-1:0] req_addr,
	input  logic [`SRAM_DATA_W-1:0] req_wdata,

	output logic rsp_valid,
	input  logic rsp_ready,
	output logic [`SRAM_DATA_W-1:0] rsp_rdata,

	output logic [`SRAM_ADDR_W-1:0] base_addr,
	inout  wire  [`SRAM_DATA_W-1:0] base_data,
	output logic base_ce_n,
	output logic base_oe_n,
	output logic base_we_n,

	output logic [`SRAM_ADDR_W-1:0] ext_addr,
	inout  wire  [`SRAM_DATA_W-1:0] ext_data,
	output logic ext_ce_n,
	output logic ext_oe_n,
	output logic ext_we_n
);
	sram_bus_if base_bus ();
	sram_bus_if ext_bus ();

	sram_bank_router u_router (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_rdata (rsp_rdata),
		.base_bus  (base_bus.router),
		.ext_bus   (ext_bus.router)
	);

	sram_bank_ctrl u_base_ctrl (
		.clk       (clk),
		.rst       (rst),
		.bus       (base_bus.ctrl),
		.sram_addr (base_addr),
		.sram_data (base_data),
		.ce_n      (base_ce_n),
		.oe_n      (base_oe_n),
		.we_n      (base_we_n)
	);

	sram_bank_ctrl u_ext_ctrl (
		.clk       (clk),
		.rst       (rst),
		.bus       (ext_bus.ctrl),
		.sram_addr (ext_addr),
		.sram_data (ext_data),
		.ce_n      (ext_ce_n),
		.oe_n      (ext_oe_n),
		.we_n      (ext_we_n)
	);

endmodule

`default_nettype wire

/* design/sram_bank_router.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_bank_router
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	output logic req_ready,
	input  sram_op_e req_op,
	input  logic [`SYS_ADDR_W-1:0] req_addr,
	input  logic [`SRAM_DATA_W-1:0] req_wdata,
	output logic rsp_valid,
	input  logic rsp_ready,
	output logic [`SRAM_DATA_W-1:0] rsp_rdata,
	sram_bus_if.router base_bus,
	sram_bus_if.router ext_bus
);
	localparam int PTR_W = (`ORDER_DEPTH > 1) ? $clog2(`ORDER_DEPTH) : 1;
	localparam int CNT_W = $clog2(`ORDER_DEPTH + 1);

	bank_id_e sel_bank;
	bank_id_e head_bank;
	bank_id_e order_q [`ORDER_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic is_read;
	logic q_full;
	logic q_empty;
	logic rd_block;
	logic push;
	logic pop;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request steering
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign sel_bank = bank_id_e'(req_addr[`SYS_ADDR_W-1]);
	assign is_read = (req_op == OP_READ);
	assign q_full = (count == CNT_W'(`ORDER_DEPTH));
	assign q_empty = (count == '0);
	assign rd_block = is_read && q_full; // No slot left to track it.

	assign req_ready = !rd_block &&
		((sel_bank == BANK_EXT) ? ext_bus.req_ready : base_bus.req_ready);

	assign base_bus.req_valid = req_valid && !rd_block && (sel_bank == BANK_BASE);
	assign ext_bus.req_valid = req_valid && !rd_block && (sel_bank == BANK_EXT);

	assign base_bus.op = req_op;
	assign ext_bus.op = req_op;
	assign base_bus.addr = req_addr[`SRAM_ADDR_W-1:0];
	assign ext_bus.addr = req_addr[`SRAM_ADDR_W-1:0];
	assign base_bus.wdata = req_wdata;
	assign ext_bus.wdata = req_wdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response merge in issue order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign head_bank = order_q[rd_ptr];

	assign rsp_valid = !q_empty &&
		((head_bank == BANK_EXT) ? ext_bus.rsp_valid : base_bus.rsp_valid);
	assign rsp_rdata = (head_bank == BANK_EXT) ? ext_bus.rdata : base_bus.rdata;

	// Only the bank at the head may hand over its data.
	assign base_bus.rsp_ready = rsp_ready && !q_empty && (head_bank == BANK_BASE);
	assign ext_bus.rsp_ready = rsp_ready && !q_empty && (head_bank == BANK_EXT);

	assign push = req_valid && req_ready && is_read;
	assign pop = rsp_valid && rsp_ready;

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`ORDER_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`ORDER_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
			case ({push, pop})
				2'b10: count <= count + CNT_W'(1);
				2'b01: count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			order_q[wr_ptr] <= sel_bank;
		end
	end

endmodule

`default_nettype wire

/* design/sram_bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_bank_ctrl
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rst,
	sram_bus_if.ctrl bus,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	inout  wire  [`SRAM_DATA_W-1:0] sram_data,
	output logic ce_n,
	output logic oe_n,
	output logic we_n
);
	bank_ctrl_state_e state;
	logic [`SRAM_DATA_W-1:0] wdata_q;
	logic [`SRAM_DATA_W-1:0] rdata_q;
	logic accept;

	assign bus.req_ready = (state == ST_IDLE); // One operation in flight.
	assign accept = bus.req_valid && bus.req_ready;
	assign bus.rsp_valid = (state == ST_RSP_HOLD);
	assign bus.rdata = rdata_q;

	// Bus is ours only when chip selected and outputs off.
	assign sram_data = (oe_n && !ce_n) ? wdata_q : {`SRAM_DATA_W{1'bz}};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobe sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= ST_IDLE;
			ce_n <= 1'b1;
			oe_n <= 1'b1;
			we_n <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					ce_n <= 1'b1;
					if (accept) begin
						if (bus.op == OP_READ) begin
							state <= ST_RD_SETUP;
						end else begin
							state <= ST_WR_SETUP;
						end
					end
				end
				ST_RD_SETUP: begin
					ce_n <= 1'b0;
					oe_n <= 1'b0; // Chip drives the bus from here.
					we_n <= 1'b1;
					state <= ST_RD_SAMPLE;
				end
				ST_RD_SAMPLE: begin
					state <= ST_RD_RELEASE; // Data captured below.
				end
				ST_RD_RELEASE: begin
					ce_n <= 1'b1;
					oe_n <= 1'b1;
					we_n <= 1'b1;
					state <= ST_RSP_HOLD;
				end
				ST_RSP_HOLD: begin
					if (bus.rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				ST_WR_SETUP: begin
					ce_n <= 1'b0;
					oe_n <= 1'b1;
					we_n <= 1'b1;
					state <= ST_WR_PULSE;
				end
				ST_WR_PULSE: begin
					we_n <= 1'b0; // Single cycle write pulse.
					state <= ST_WR_RELEASE;
				end
				ST_WR_RELEASE: begin
					ce_n <= 1'b1;
					oe_n <= 1'b1;
					we_n <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address and data registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (accept) begin
			sram_addr <= bus.addr; // Settles a cycle ahead of the strobes.
			wdata_q <= bus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_RD_SAMPLE) begin
			rdata_q <= sram_data; // Held through ST_RSP_HOLD.
		end
	end

endmodule

`default_nettype wire

/* design/sram_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

interface sram_bus_if
	import sram_pkg::*;
();
	// Request channel.
	logic req_valid;
	logic req_ready;
	sram_op_e op;
	logic [`SRAM_ADDR_W-1:0] addr;
	logic [`SRAM_DATA_W-1:0] wdata;

	// Read response channel.
	logic rsp_valid;
	logic rsp_ready;
	logic [`SRAM_DATA_W-1:0] rdata;

	modport router (
		output req_valid, op, addr, wdata, rsp_ready,
		input  req_ready, rsp_valid, rdata
	);

	modport ctrl (
		input  req_valid, op, addr, wdata, rsp_ready,
		output req_ready, rsp_valid, rdata
	);

endinterface

`default_nettype wire

/* design/sram_pkg.sv */
`default_nettype none

package sram_pkg;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} sram_op_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bank controller FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_RD_SETUP   = 3'd1,
		ST_RD_SAMPLE  = 3'd2,
		ST_RD_RELEASE = 3'd3,
		ST_RSP_HOLD   = 3'd4, // Read data held until taken.
		ST_WR_SETUP   = 3'd5,
		ST_WR_PULSE   = 3'd6,
		ST_WR_RELEASE = 3'd7
	} bank_ctrl_state_e;

	typedef enum logic {
		BANK_BASE = 1'b0,
		BANK_EXT  = 1'b1
	} bank_id_e;

endpackage

`default_nettype wire

/* include/sram_config.svh */
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SRAM_ADDR_W 20 // Address pins per chip.
`define SYS_ADDR_W 21 // Top bit picks the bank.
`define SRAM_DATA_W 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ORDER_DEPTH 2 // One outstanding read per bank.

`endif
